/* compile.f */
+incdir+.
test_pkg.sv
sata_scrambler.sv
test_tx.sv
test_link.sv
test_rx.sv
test_top.sv
tb_test_top.sv

/* tb_test_tasks.svh */
/* directed tests, included inside the testbench top module.
   each test leaves start low and the generator idle. */

`ifndef tb_test_tasks_svh
`define tb_test_tasks_svh

task automatic reset_state_test();
    begin_test("reset_state");
    repeat (20) begin
        @(negedge clk);
        check_level("mac_tx_rq", 1'b0, mac_tx_rq);
        check_count("pkt_count", 16'd0, pkt_count);
        check_count("err_count", 16'd0, err_count);
        check_count("frame_err_count", 16'd0, frame_err_count);
        check_len("last_len", 16'd0, last_len);
    end
    end_test();
endtask

task automatic single_packet_test();
    begin_test("single_packet");
    send_packets(1, 1'b0, 16'd6, 16'd3, 1'b0, 1'b0);
    check_count("pkt_count", 16'd1, pkt_count);
    check_len("last_len", 16'd6, last_len);
    check_count("err_count", 16'd0, err_count);
    check_count("frame_err_count", 16'd0, frame_err_count);
    idle_check(12);
    end_test();
endtask

// the hold is longer than a whole packet plus the link, so an early start shows up.
task automatic ack_holdoff_test();
    len_t base;
    int   hold;
    begin_test("ack_holdoff");
    base = pkt_count;
    hold = $urandom_range(16, 10);
    @(negedge clk);
    mac_tx_ack = 1'b0;
    pkt_size   = 16'd5;
    pause_size = 16'd2;
    start      = 1'b1;
    wait_rq(1'b1, 50);
    repeat (hold) begin
        @(negedge clk);
        check_level("mac_tx_rq", 1'b1, mac_tx_rq);
        check_count("pkt_count", base, pkt_count);
    end
    mac_tx_ack = 1'b1;
    @(negedge clk);
    start = 1'b0; // already in transmit.
    wait_count(base + 16'd1, 100);
    check_len("last_len", 16'd5, last_len);
    check_count("err_count", 16'd0, err_count);
    check_count("frame_err_count", 16'd0, frame_err_count);
    idle_check(12);
    end_test();
endtask

// the second burst starts from idle, so both scramblers re-seed.
task automatic repeated_packets_test();
    len_t base;
    begin_test("repeated_packets");
    base = pkt_count;
    send_packets(8, 1'b1, 16'd0, 16'd0, 1'b0, 1'b0);
    idle_check(12);
    send_packets(3, 1'b1, 16'd0, 16'd0, 1'b0, 1'b0);
    check_count("pkt_count", base + 16'd11, pkt_count);
    check_count("err_count", 16'd0, err_count);
    check_count("frame_err_count", 16'd0, frame_err_count);
    idle_check(12);
    end_test();
endtask

task automatic error_inject_test();
    len_t base_err;
    begin_test("error_inject");
    base_err = err_count;
    send_packets(4, 1'b1, 16'd0, 16'd0, 1'b1, 1'b0);
    check_count("err_count", base_err + 16'd4, err_count);
    check_count("frame_err_count", 16'd0, frame_err_count);
    idle_check(12);
    end_test();
endtask

task automatic min_size_test();
    len_t base;
    len_t base_err;
    begin_test("min_size");
    base     = pkt_count;
    base_err = err_count;
    send_packets(5, 1'b0, len_t'(min_pkt_size), 16'd1, 1'b0, 1'b1);
    check_count("pkt_count", base + 16'd5, pkt_count);
    check_len("last_len", len_t'(min_pkt_size), last_len);
    check_count("err_count", base_err, err_count);
    check_count("frame_err_count", 16'd0, frame_err_count);
    idle_check(12);
    end_test();
endtask

`endif

/* tb_test_top.sv */
/* testbench for the link test top. inputs change on the falling clock edge and
   outputs are sampled there as well. random sizes come from one fixed seed. */

`timescale 1ns/1ps

module tb_test_top;

    import test_pkg::*;

    logic clk;
    logic reset;
    logic start;
    len_t pkt_size;
    len_t pause_size;
    logic mac_tx_ack;
    logic err_inject;
    logic mac_tx_rq;
    len_t pkt_count;
    len_t err_count;
    len_t frame_err_count;
    len_t last_len;

    string cur_test;
    int    n_tests;
    int    n_checks;
    int    n_errors;
    int    test_errors;
    bit    timed_out;
    int    seed;

    test_top dut_i (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .pkt_size        (pkt_size),
        .pause_size      (pause_size),
        .mac_tx_ack      (mac_tx_ack),
        .err_inject      (err_inject),
        .mac_tx_rq       (mac_tx_rq),
        .pkt_count       (pkt_count),
        .err_count       (err_count),
        .frame_err_count (frame_err_count),
        .last_len        (last_len)
    );

    always #20 clk = ~clk; // 40 ns period.

    task automatic check_len(input string what, input len_t exp, input len_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input len_t exp, input len_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_level(input string what, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: %s expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = n_errors;
        n_tests++;
    endtask

    task automatic end_test();
        if (n_errors == test_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: failed with %0d errors", cur_test, n_errors - test_errors);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        timed_out = 1'b1;
        $display("%s: timed out waiting for %s", cur_test, what);
    endtask

    task automatic wait_count(input len_t target, input int limit);
        int cycles;
        cycles = 0;
        while (pkt_count !== target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (pkt_count !== target) begin
            report_timeout("pkt_count to advance");
        end
    endtask

    task automatic wait_rq(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (mac_tx_rq !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (mac_tx_rq !== level) begin
            report_timeout("mac_tx_rq");
        end
    endtask

    // start low, so no request may show up.
    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_level("mac_tx_rq", 1'b0, mac_tx_rq);
        end
    endtask

    task automatic pick_sizes();
        pkt_size   = len_t'($urandom_range(min_pkt_size + 14, min_pkt_size));
        pause_size = len_t'($urandom_range(8, 1));
    endtask

    // sizes are latched on the edge where mac_tx_rq rises with ack high.
    task automatic send_packets(input int n, input bit rand_sizes, input len_t size,
                                input len_t pause, input bit inject, input bit check_gap);
        len_t exp_q[$];
        len_t seen;
        int   started;
        int   done;
        int   cycles;
        int   gap;
        logic rq_prev;
        seen    = pkt_count;
        started = 0;
        done    = 0;
        cycles  = 0;
        gap     = 0;
        rq_prev = mac_tx_rq;
        @(negedge clk);
        if (rand_sizes) begin
            pick_sizes();
        end else begin
            pkt_size   = size;
            pause_size = pause;
        end
        mac_tx_ack = 1'b1;
        start      = 1'b1;
        while (done < n && cycles < 4000) begin
            @(negedge clk);
            cycles++;
            err_inject = 1'b0;
            if (mac_tx_rq && !rq_prev) begin
                if (check_gap && started > 0) begin
                    n_checks++;
                    if (gap < 2) begin
                        n_errors++;
                        $display("%s: only %0d idle cycles between requests", cur_test, gap);
                    end
                end
                exp_q.push_back(pkt_size);
                started++;
                gap = 0;
                if (inject) begin
                    err_inject = 1'b1; // hits the first word.
                end
                if (started == n) begin
                    start = 1'b0;
                end else if (rand_sizes) begin
                    pick_sizes();
                end
            end else if (!mac_tx_rq) begin
                gap++;
            end
            if (pkt_count !== seen) begin
                seen = pkt_count;
                done++;
                if (exp_q.size() > 0) begin
                    check_len("last_len", exp_q.pop_front(), last_len);
                end else begin
                    n_errors++;
                    $display("%s: a packet was counted that was never requested", cur_test);
                end
            end
            rq_prev = mac_tx_rq;
        end
        err_inject = 1'b0;
        start      = 1'b0;
        if (done < n) begin
            report_timeout("all packets to be counted");
        end
    endtask

    `include "tb_test_tasks.svh"

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        pkt_size    = 16'd4;
        pause_size  = 16'd2;
        mac_tx_ack  = 1'b1;
        err_inject  = 1'b0;
        n_tests     = 0;
        n_checks    = 0;
        n_errors    = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        seed        = 32'h51e9a17e;
        seed        = $urandom(seed);
        repeat (8) @(negedge clk);
        reset = 1'b0;

        reset_state_test();
        if (!timed_out) single_packet_test();
        if (!timed_out) ack_holdoff_test();
        if (!timed_out) repeated_packets_test();
        if (!timed_out) error_inject_test();
        if (!timed_out) min_size_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* test_top.sv */
/* link test top: generator, fixed-delay link and checker.
   counters show a packet link_delay+1 cycles after its eof leaves the generator. */

`timescale 1ns/1ps

module test_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  test_pkg::len_t pkt_size,
    input  test_pkg::len_t pause_size,
    input  logic           mac_tx_ack,
    input  logic           err_inject,
    output logic           mac_tx_rq,
    output test_pkg::len_t pkt_count,
    output test_pkg::len_t err_count,
    output test_pkg::len_t frame_err_count,
    output test_pkg::len_t last_len
);

    import test_pkg::*;

    word_t mac_tx_data;
    logic  mac_tx_valid;
    logic  mac_tx_sof;
    logic  mac_tx_eof;
    logic  seq_init;
    word_t rx_data;
    logic  rx_valid;
    logic  rx_sof;
    logic  rx_eof;
    logic  rx_seq_init;

    test_tx tx_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .pkt_size     (pkt_size),
        .pause_size   (pause_size),
        .mac_tx_ack   (mac_tx_ack),
        .mac_tx_data  (mac_tx_data),
        .mac_tx_valid (mac_tx_valid),
        .mac_tx_sof   (mac_tx_sof),
        .mac_tx_eof   (mac_tx_eof),
        .mac_tx_rq    (mac_tx_rq),
        .seq_init     (seq_init)
    );

    test_link link_i (
        .clk          (clk),
        .reset        (reset),
        .in_data      (mac_tx_data),
        .in_valid     (mac_tx_valid),
        .in_sof       (mac_tx_sof),
        .in_eof       (mac_tx_eof),
        .in_seq_init  (seq_init),
        .err_inject   (err_inject),
        .out_data     (rx_data),
        .out_valid    (rx_valid),
        .out_sof      (rx_sof),
        .out_eof      (rx_eof),
        .out_seq_init (rx_seq_init)
    );

    test_rx rx_i (
        .clk             (clk),
        .reset           (reset),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .rx_sof          (rx_sof),
        .rx_eof          (rx_eof),
        .rx_seq_init     (rx_seq_init),
        .pkt_count       (pkt_count),
        .err_count       (err_count),
        .frame_err_count (frame_err_count),
        .last_len        (last_len)
    );

endmodule

/* test_rx.sv */
/* receive checker. compares each word with a local scrambler and checks framing.
   counters update one cycle after the word, they wrap at 16 bits. */

`timescale 1ns/1ps

module test_rx (
    input  logic            clk,
    input  logic            reset,
    input  test_pkg::word_t rx_data,
    input  logic            rx_valid,
    input  logic            rx_sof,
    input  logic            rx_eof,
    input  logic            rx_seq_init,
    output test_pkg::len_t  pkt_count,
    output test_pkg::len_t  err_count,
    output test_pkg::len_t  frame_err_count,
    output test_pkg::len_t  last_len
);

    import test_pkg::*;

    word_t expected;
    logic  in_pkt;    // a packet is open.
    len_t  cur_len;
    logic  pkt_open;
    len_t  word_len;
    logic  data_err;
    logic  frame_err;

    sata_scrambler scrambler_i (
        .clk     (clk),
        .reset   (reset),
        .restart (rx_seq_init),
        .en      (rx_valid),
        .result  (expected)
    );

    assign pkt_open = in_pkt | (rx_valid & rx_sof);
    assign word_len = rx_sof ? 16'd1 : cur_len + 16'd1;
    assign data_err = rx_valid && (rx_data != expected);

    // one count per cycle, however many rules trip.
    always_comb begin
        frame_err = 1'b0;
        if (rx_sof && in_pkt) begin
            frame_err = 1'b1; // sof inside a packet.
        end
        if (rx_valid && !pkt_open) begin
            frame_err = 1'b1; // stray word.
        end
        if (in_pkt && !rx_valid) begin
            frame_err = 1'b1; // gap.
        end
        if (rx_eof && !pkt_open) begin
            frame_err = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt          <= 1'b0;
            cur_len         <= '0;
            pkt_count       <= '0;
            err_count       <= '0;
            frame_err_count <= '0;
            last_len        <= '0;
        end else begin
            // a gap aborts the packet, so one fault is counted once.
            in_pkt <= rx_valid && !rx_eof && pkt_open;
            if (rx_valid) begin
                cur_len <= word_len;
            end
            if (data_err) begin
                err_count <= err_count + 16'd1;
            end
            if (frame_err) begin
                frame_err_count <= frame_err_count + 16'd1;
            end
            if (rx_valid && rx_eof && pkt_open) begin
                pkt_count <= pkt_count + 16'd1;
                last_len  <= word_len;
            end
        end
    end

endmodule

/* test_link.sv */
/* fixed-delay link model, latency is link_delay cycles.
   err_inject flips bit 0 of a valid word as it enters. */

`timescale 1ns/1ps

module test_link (
    input  logic            clk,
    input  logic            reset,
    input  test_pkg::word_t in_data,
    input  logic            in_valid,
    input  logic            in_sof,
    input  logic            in_eof,
    input  logic            in_seq_init,
    input  logic            err_inject,
    output test_pkg::word_t out_data,
    output logic            out_valid,
    output logic            out_sof,
    output logic            out_eof,
    output logic            out_seq_init
);

    import test_pkg::*;

    word_t      data_q [link_delay];
    logic [3:0] ctrl_q [link_delay]; // {seq_init, eof, sof, valid}.
    word_t      flip;

    assign flip = {{(data_width-1){1'b0}}, err_inject & in_valid};

    always_ff @(posedge clk) begin
        data_q[0] <= in_data ^ flip;
        for (int i = 1; i < link_delay; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < link_delay; i++) begin
                ctrl_q[i] <= 4'b0000;
            end
        end else begin
            ctrl_q[0] <= {in_seq_init, in_eof, in_sof, in_valid};
            for (int i = 1; i < link_delay; i++) begin
                ctrl_q[i] <= ctrl_q[i-1];
            end
        end
    end

    assign out_data     = data_q[link_delay-1];
    assign out_valid    = ctrl_q[link_delay-1][0];
    assign out_sof      = ctrl_q[link_delay-1][1];
    assign out_eof      = ctrl_q[link_delay-1][2];
    assign out_seq_init = ctrl_q[link_delay-1][3];

endmodule

/* test_tx.sv */
/* packet generator. pkt_size must be at least min_pkt_size and pause_size at least 1.
   once a packet starts it runs to eof, ack only delays the start. */

`timescale 1ns/1ps

module test_tx (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  test_pkg::len_t  pkt_size,
    input  test_pkg::len_t  pause_size,
    input  logic            mac_tx_ack,
    output test_pkg::word_t mac_tx_data,
    output logic            mac_tx_valid,
    output logic            mac_tx_sof,
    output logic            mac_tx_eof,
    output logic            mac_tx_rq,
    output logic            seq_init
);

    import test_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_req_wait,
        st_xmit,
        st_pause
    } state_t;

    state_t state;
    len_t   cnt;       // word count in xmit, idle count in pause.
    len_t   pkt_len;
    len_t   pause_len;

    sata_scrambler scrambler_i (
        .clk     (clk),
        .reset   (reset),
        .restart (seq_init),
        .en      (mac_tx_valid),
        .result  (mac_tx_data)
    );

    // sizes are taken once per packet.
    always_ff @(posedge clk) begin
        if (state == st_req_wait) begin
            pkt_len   <= pkt_size;
            pause_len <= pause_size;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            cnt          <= '0;
            mac_tx_valid <= 1'b0;
            mac_tx_sof   <= 1'b0;
            mac_tx_eof   <= 1'b0;
            mac_tx_rq    <= 1'b0;
            seq_init     <= 1'b0;
        end else begin
            seq_init <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        seq_init <= 1'b1; // re-seed only when leaving idle.
                        state    <= st_req_wait;
                    end
                end

                st_req_wait: begin
                    cnt <= '0;
                    if (!start) begin
                        mac_tx_rq <= 1'b0;
                        state     <= st_idle;
                    end else begin
                        mac_tx_rq <= 1'b1;
                        if (mac_tx_ack) begin
                            mac_tx_valid <= 1'b1;
                            mac_tx_sof   <= 1'b1;
                            state        <= st_xmit;
                        end
                    end
                end

                st_xmit: begin
                    mac_tx_sof <= 1'b0;
                    if (cnt == pkt_len - 16'd2) begin
                        mac_tx_eof <= 1'b1;
                        mac_tx_rq  <= 1'b0; // release together with eof.
                    end
                    if (cnt == pkt_len - 16'd1) begin
                        mac_tx_valid <= 1'b0;
                        mac_tx_eof   <= 1'b0;
                        cnt          <= '0;
                        state        <= st_pause;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end

                st_pause: begin
                    if (cnt == pause_len - 16'd1) begin
                        cnt   <= '0;
                        state <= start ? st_req_wait : st_idle;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* sata_scrambler.sv */
/* parallel 16-bit LFSR scrambler, one word per enabled cycle.
   restart wins over en and loads the seed for the next cycle. */

`timescale 1ns/1ps

module sata_scrambler (
    input  logic          clk,
    input  logic          reset,
    input  logic          restart,
    input  logic          en,
    output test_pkg::word_t result
);

    import test_pkg::*;

    logic [15:0] state;
    logic [15:0] state_next;
    word_t       bits;

    // unroll the serial LFSR over one lane word.
    always_comb begin
        logic [15:0] s;
        s = state;
        for (int i = 0; i < data_width; i++) begin
            bits[i] = s[15];
            s = {s[14:0], 1'b0} ^ (s[15] ? scr_poly : 16'h0000);
        end
        state_next = s;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= scr_init;
        end else if (restart) begin
            state <= scr_init;
        end else if (en) begin
            state <= state_next; // step by a whole word.
        end
    end

    assign result = bits; // word for the current state.

endmodule

/* test_pkg.sv */
/* shared constants and types for the link test source and checker.
   the lane is fixed at 32 bits and the link delay is fixed at build time. */

package test_pkg;

    // lane width in bits.
    localparam int data_width = 32;

    // one data word on the lane.
    typedef logic [data_width-1:0] word_t;

    // packet length, pause length and counters.
    typedef logic [15:0] len_t;

    // scrambler seed, loaded on every sequence restart.
    localparam logic [15:0] scr_init = 16'h55aa;

    // x^16 + x^15 + x^13 + x^4 + 1, the x^16 term is implied.
    localparam logic [15:0] scr_poly = 16'ha011;

    // clock cycles through the link model.
    localparam int link_delay = 3;

    // smallest legal packet length.
    localparam int min_pkt_size = 2;

endpackage
